// ==== build.f ====
design/hwce_arith_pkg.sv
design/hwce_cfg_pkg.sv
design/hwce_regfile.sv
design/hwce_weight_mem.sv
design/hwce_weight_loader.sv
design/hwce_conv_engine.sv
design/hwce_top.sv
dv/tb_clk_gen.sv
dv/tb_hwce_top.sv

// ==== Bender.yml ====
package:
  name: hwce_lite

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - design/hwce_arith_pkg.sv
      - design/hwce_cfg_pkg.sv
      - design/hwce_regfile.sv
      - design/hwce_weight_mem.sv
      - design/hwce_weight_loader.sv
      - design/hwce_conv_engine.sv
      - design/hwce_top.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_hwce_top.sv

// ==== dv/tb_hwce_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_hwce_top;

  localparam int TBL_DEPTH     = 256;
  localparam int CYCLES_PER_OP = 16;
  localparam int FSIZE         = hwce_arith_pkg::FILTER_SIZE;
  localparam int EVT_WAIT      = hwce_arith_pkg::FILTER_SIZE + 3;
  localparam longint SAMPLE_MAX = (longint'(1) << (hwce_arith_pkg::SAMPLE_WIDTH - 1)) - 1;
  localparam longint SAMPLE_MIN = -(longint'(1) << (hwce_arith_pkg::SAMPLE_WIDTH - 1));

  typedef enum {OP_WR, OP_RD, OP_WMEM, OP_EVT, OP_SMP, OP_IDLE, OP_DRAIN} op_e;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       cfg_req;
  logic                                       cfg_we;
  hwce_cfg_pkg::cfg_reg_e                     cfg_addr;
  logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]    cfg_wdata;
  logic                                       cfg_rvalid;
  logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]    cfg_rdata;
  logic                                       wmem_we;
  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] wmem_addr;
  hwce_arith_pkg::sample_t                    wmem_wdata;
  logic                                       x_valid;
  hwce_arith_pkg::sample_t                    x_data;
  logic                                       y_valid;
  hwce_arith_pkg::sample_t                    y_data;
  logic                                       evt_interrupt;
  logic                                       expect_out;

  // operation table
  op_e         tbl_op   [TBL_DEPTH];
  int          tbl_addr [TBL_DEPTH];
  logic [15:0] tbl_data [TBL_DEPTH];
  bit          tbl_has  [TBL_DEPTH];
  longint      tbl_exp  [TBL_DEPTH];
  int          tbl_n = 0;

  // reference model state
  longint      m_mem  [hwce_arith_pkg::WMEM_DEPTH];
  longint      m_taps [FSIZE];
  longint      m_win  [FSIZE];
  longint      m_bias = 0;
  int          m_wbase = 0;
  int          m_qf = 0;
  int          m_fill = 0;
  int          m_loads = 0;
  bit          m_relu = 1'b0;

  logic [31:0] lcg_state = 32'h2f435ac2;
  longint      exp_q [$];
  longint      got_q [$];
  int          evt_cnt = 0;
  int          cyc_cnt = 0;
  int          cycle_limit = 0;
  bit          vld_d1 = 1'b0;
  bit          vld_d2 = 1'b0;
  bit          rd_d1 = 1'b0;

  tb_clk_gen clk_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  hwce_top uut (
    .clk_fast_i      ( clk           ),
    .rst_n           ( rst_n         ),
    .cfg_req_i       ( cfg_req       ),
    .cfg_we_i        ( cfg_we        ),
    .cfg_addr_i      ( cfg_addr      ),
    .cfg_wdata_i     ( cfg_wdata     ),
    .cfg_rvalid_o    ( cfg_rvalid    ),
    .cfg_rdata_o     ( cfg_rdata     ),
    .wmem_we_i       ( wmem_we       ),
    .wmem_addr_i     ( wmem_addr     ),
    .wmem_wdata_i    ( wmem_wdata    ),
    .x_valid_i       ( x_valid       ),
    .x_data_i        ( x_data        ),
    .y_valid_o       ( y_valid       ),
    .y_data_o        ( y_data        ),
    .evt_interrupt_o ( evt_interrupt )
  );

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(string name, logic signed [63:0] got, logic signed [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic longint rand_signed(int bits);
    longint span;
    span = longint'(1) << bits;
    return longint'(lcg_next() >> 8) % span - span / 2;
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic longint model_output();
    longint acc;
    longint res;
    acc = m_bias * (longint'(1) << m_qf);
    for (int k = 0; k < FSIZE; k++) begin
      acc += m_taps[k] * m_win[k];
    end
    // floor division by 2^qf
    res = acc >>> m_qf;
    if (res > SAMPLE_MAX) begin
      res = SAMPLE_MAX;
    end else if (res < SAMPLE_MIN) begin
      res = SAMPLE_MIN;
    end
    if (m_relu && res < 0) begin
      res = 0;
    end
    return res;
  endfunction

  function automatic void add_entry(op_e op, int addr, logic [15:0] data, bit has, longint exp);
    tbl_op[tbl_n]   = op;
    tbl_addr[tbl_n] = addr;
    tbl_data[tbl_n] = data;
    tbl_has[tbl_n]  = has;
    tbl_exp[tbl_n]  = exp;
    tbl_n++;
  endfunction

  function automatic void add_write(hwce_cfg_pkg::cfg_reg_e addr, logic [15:0] data);
    add_entry(OP_WR, int'(addr), data, 1'b0, 0);
    case (addr)
      hwce_cfg_pkg::REG_WBASE: m_wbase = int'(data) % hwce_arith_pkg::WMEM_DEPTH;
      hwce_cfg_pkg::REG_BIAS:  m_bias = longint'($signed(data));
      hwce_cfg_pkg::REG_QF:    m_qf = int'(data) % 16;
      hwce_cfg_pkg::REG_FLAGS: m_relu = data[hwce_cfg_pkg::FLAG_RELU];
      default: ;
    endcase
  endfunction

  function automatic void add_read(hwce_cfg_pkg::cfg_reg_e addr, longint exp);
    add_entry(OP_RD, int'(addr), '0, 1'b1, exp);
  endfunction

  function automatic void add_wmem(int addr, longint v);
    add_entry(OP_WMEM, addr, 16'(v), 1'b0, 0);
    m_mem[addr] = v;
  endfunction

  // second trigger lands in the drain cycle while still busy and must be dropped
  function automatic void add_load();
    add_write(hwce_cfg_pkg::REG_TRIGGER, 16'h0001);
    add_read(hwce_cfg_pkg::REG_STATUS, 1);
    // wait until the loader reaches its drain cycle
    for (int k = 0; k < FSIZE - 1; k++) begin
      add_entry(OP_IDLE, 0, '0, 1'b0, 0);
    end
    add_write(hwce_cfg_pkg::REG_TRIGGER, 16'h0001);
    add_entry(OP_EVT, 0, '0, 1'b0, 0);
    add_read(hwce_cfg_pkg::REG_STATUS, 0);
    for (int k = 0; k < FSIZE; k++) begin
      m_taps[k] = m_mem[(m_wbase + k) % hwce_arith_pkg::WMEM_DEPTH];
    end
    m_fill = 0;
    m_loads++;
  endfunction

  function automatic void add_sample(longint x);
    for (int k = FSIZE - 1; k > 0; k--) begin
      m_win[k] = m_win[k-1];
    end
    m_win[0] = x;
    if (m_fill < FSIZE) begin
      m_fill++;
    end
    if (m_fill == FSIZE) begin
      add_entry(OP_SMP, 0, 16'(x), 1'b1, model_output());
    end else begin
      add_entry(OP_SMP, 0, 16'(x), 1'b0, 0);
    end
  endfunction

  function automatic void build_table();
    longint big_taps [FSIZE] = '{32767, -32768, 32767, 32767, -32768};
    // everything reads zero out of reset
    for (int r = 0; r <= int'(hwce_cfg_pkg::REG_STATUS); r++) begin
      add_read(hwce_cfg_pkg::cfg_reg_e'(r), 0);
    end
    add_write(hwce_cfg_pkg::REG_WBASE, 16'h002a);
    add_write(hwce_cfg_pkg::REG_BIAS, 16'hbeef);
    add_write(hwce_cfg_pkg::REG_QF, 16'h0007);
    add_write(hwce_cfg_pkg::REG_FLAGS, 16'h0001);
    add_write(hwce_cfg_pkg::REG_STATUS, 16'hffff);
    add_read(hwce_cfg_pkg::REG_WBASE, 16'h002a);
    add_read(hwce_cfg_pkg::REG_BIAS, 16'hbeef);
    add_read(hwce_cfg_pkg::REG_QF, 16'h0007);
    add_read(hwce_cfg_pkg::REG_FLAGS, 16'h0001);
    add_read(hwce_cfg_pkg::REG_STATUS, 0);

    // first filter based near the top so the fetch wraps
    for (int k = 0; k < FSIZE; k++) begin
      add_wmem((61 + k) % hwce_arith_pkg::WMEM_DEPTH, rand_signed(9));
    end
    add_write(hwce_cfg_pkg::REG_WBASE, 16'd61);
    add_write(hwce_cfg_pkg::REG_BIAS, 16'(rand_signed(10)));
    add_write(hwce_cfg_pkg::REG_QF, 16'(6 + lcg_next() % 8));
    add_write(hwce_cfg_pkg::REG_FLAGS, 16'h0000);
    add_load();
    for (int n = 0; n < 24; n++) begin
      add_sample(rand_signed(12));
      if (lcg_next() % 5 == 0) begin
        add_entry(OP_IDLE, 0, '0, 1'b0, 0);
      end
    end
    add_entry(OP_DRAIN, 0, '0, 1'b0, 0);

    // second filter with full-scale taps
    for (int k = 0; k < FSIZE; k++) begin
      add_wmem(10 + k, big_taps[k]);
    end
    add_write(hwce_cfg_pkg::REG_WBASE, 16'd10);
    add_write(hwce_cfg_pkg::REG_BIAS, 16'h0000);
    add_write(hwce_cfg_pkg::REG_QF, 16'h0000);
    add_load();
    for (int n = 0; n < 6; n++) begin
      add_sample(SAMPLE_MAX);
    end
    for (int n = 0; n < 6; n++) begin
      add_sample(SAMPLE_MIN);
    end
    for (int n = 0; n < 8; n++) begin
      add_sample(rand_signed(16));
    end
    add_entry(OP_DRAIN, 0, '0, 1'b0, 0);
    add_write(hwce_cfg_pkg::REG_FLAGS, 16'h0001);
    for (int n = 0; n < 12; n++) begin
      add_sample(rand_signed(16));
    end
    add_entry(OP_DRAIN, 0, '0, 1'b0, 0);
    add_read(hwce_cfg_pkg::REG_FLAGS, 1);
  endfunction

  ////////////////////
  // driver helpers
  ////////////////////
  task automatic drive_idle();
    cfg_req    <= 1'b0;
    cfg_we     <= 1'b0;
    wmem_we    <= 1'b0;
    x_valid    <= 1'b0;
    expect_out <= 1'b0;
  endtask

  task automatic read_register(longint exp);
    bit seen;
    seen = 1'b0;
    @(posedge clk);
    drive_idle();
    for (int w = 0; w < 3 && !seen; w++) begin
      @(negedge clk);
      seen = cfg_rvalid;
    end
    if (!seen) begin
      abort_run("no read response on cfg_rvalid_o");
    end
    compare_value("cfg_rdata_o", cfg_rdata, exp);
  endtask

  task automatic wait_event();
    bit seen;
    seen = 1'b0;
    for (int w = 0; w < EVT_WAIT && !seen; w++) begin
      @(negedge clk);
      seen = evt_interrupt;
    end
    if (!seen) begin
      abort_run("no load event");
    end
  endtask

  task automatic drain_outputs();
    repeat (4) @(negedge clk);
    compare_value("y_valid_o count", got_q.size(), exp_q.size());
    while (exp_q.size() > 0) begin
      compare_value("y_data_o", got_q.pop_front(), exp_q.pop_front());
    end
  endtask

  // output monitor with each result due two cycles after its sample
  // and each read answered on the next cycle
  always @(negedge clk) begin
    if (rst_n) begin
      compare_value("y_valid_o", y_valid, vld_d2);
      compare_value("cfg_rvalid_o", cfg_rvalid, rd_d1);
      if (y_valid) begin
        got_q.push_back(y_data);
      end
      if (evt_interrupt) begin
        evt_cnt++;
      end
      vld_d2 = vld_d1;
      vld_d1 = x_valid & expect_out;
      rd_d1  = cfg_req & ~cfg_we;
    end
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > cycle_limit) begin
      abort_run("simulation hung, cycle limit reached");
    end
  end

  initial begin
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = hwce_cfg_pkg::REG_TRIGGER;
    cfg_wdata  = '0;
    wmem_we    = 1'b0;
    wmem_addr  = '0;
    wmem_wdata = '0;
    x_valid    = 1'b0;
    x_data     = '0;
    expect_out = 1'b0;
    build_table();
    cycle_limit = 40 + tbl_n * CYCLES_PER_OP;
    wait (rst_n === 1'b1);

    for (int i = 0; i < tbl_n; i++) begin
      @(posedge clk);
      drive_idle();
      case (tbl_op[i])
        OP_WR: begin
          cfg_req   <= 1'b1;
          cfg_we    <= 1'b1;
          cfg_addr  <= hwce_cfg_pkg::cfg_reg_e'(tbl_addr[i]);
          cfg_wdata <= tbl_data[i];
        end
        OP_RD: begin
          cfg_req  <= 1'b1;
          cfg_addr <= hwce_cfg_pkg::cfg_reg_e'(tbl_addr[i]);
          read_register(tbl_exp[i]);
        end
        OP_WMEM: begin
          wmem_we    <= 1'b1;
          wmem_addr  <= hwce_arith_pkg::WMEM_ADDR_WIDTH'(tbl_addr[i]);
          wmem_wdata <= hwce_arith_pkg::sample_t'(tbl_data[i]);
        end
        OP_SMP: begin
          x_valid    <= 1'b1;
          x_data     <= hwce_arith_pkg::sample_t'(tbl_data[i]);
          expect_out <= tbl_has[i];
          if (tbl_has[i]) begin
            exp_q.push_back(tbl_exp[i]);
          end
        end
        OP_EVT:   wait_event();
        OP_DRAIN: drain_outputs();
        default: ;
      endcase
    end

    repeat (4) @(negedge clk);
    compare_value("evt_interrupt_o count", evt_cnt, m_loads);
    compare_value("y_valid_o count", got_q.size(), exp_q.size());
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/hwce_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hwce_top (
  input  logic                                       clk_fast_i,
  input  logic                                       rst_n,
  // host configuration port
  input  logic                                       cfg_req_i,
  input  logic                                       cfg_we_i,
  input  hwce_cfg_pkg::cfg_reg_e                     cfg_addr_i,
  input  logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]    cfg_wdata_i,
  output logic                                       cfg_rvalid_o,
  output logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]    cfg_rdata_o,
  // weight write port
  input  logic                                       wmem_we_i,
  input  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] wmem_addr_i,
  input  hwce_arith_pkg::sample_t                    wmem_wdata_i,
  // sample stream
  input  logic                                       x_valid_i,
  input  hwce_arith_pkg::sample_t                    x_data_i,
  output logic                                       y_valid_o,
  output hwce_arith_pkg::sample_t                    y_data_o,
  output logic                                       evt_interrupt_o
);

  logic                                       load_start;
  logic                                       load_done;
  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] wbase;
  hwce_arith_pkg::sample_t                    bias;
  logic [hwce_arith_pkg::QF_WIDTH-1:0]        qf;
  logic                                       relu_en;
  logic                                       mem_rd_en;
  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] mem_rd_addr;
  hwce_arith_pkg::sample_t                    mem_rd_data;
  hwce_arith_pkg::sample_t                    taps [hwce_arith_pkg::FILTER_SIZE];

  hwce_regfile regfile_i (
    .clk_fast_i      ( clk_fast_i      ),
    .rst_n           ( rst_n           ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_we_i        ( cfg_we_i        ),
    .cfg_addr_i      ( cfg_addr_i      ),
    .cfg_wdata_i     ( cfg_wdata_i     ),
    .cfg_rvalid_o    ( cfg_rvalid_o    ),
    .cfg_rdata_o     ( cfg_rdata_o     ),
    .load_done_i     ( load_done       ),
    .load_start_o    ( load_start      ),
    .wbase_o         ( wbase           ),
    .bias_o          ( bias            ),
    .qf_o            ( qf              ),
    .relu_en_o       ( relu_en         ),
    .evt_interrupt_o ( evt_interrupt_o )
  );

  hwce_weight_mem weight_mem_i (
    .clk_fast_i ( clk_fast_i   ),
    .wr_en_i    ( wmem_we_i    ),
    .wr_addr_i  ( wmem_addr_i  ),
    .wr_data_i  ( wmem_wdata_i ),
    .rd_en_i    ( mem_rd_en    ),
    .rd_addr_i  ( mem_rd_addr  ),
    .rd_data_o  ( mem_rd_data  )
  );

  hwce_weight_loader weight_loader_i (
    .clk_fast_i    ( clk_fast_i  ),
    .rst_n         ( rst_n       ),
    .start_i       ( load_start  ),
    .base_addr_i   ( wbase       ),
    .mem_rd_en_o   ( mem_rd_en   ),
    .mem_rd_addr_o ( mem_rd_addr ),
    .mem_rd_data_i ( mem_rd_data ),
    .taps_o        ( taps        ),
    .done_o        ( load_done   )
  );

  // load_start also empties the sample window
  hwce_conv_engine conv_engine_i (
    .clk_fast_i ( clk_fast_i ),
    .rst_n      ( rst_n      ),
    .clear_i    ( load_start ),
    .taps_i     ( taps       ),
    .bias_i     ( bias       ),
    .qf_i       ( qf         ),
    .relu_en_i  ( relu_en    ),
    .x_valid_i  ( x_valid_i  ),
    .x_data_i   ( x_data_i   ),
    .y_valid_o  ( y_valid_o  ),
    .y_data_o   ( y_data_o   )
  );

endmodule

`default_nettype wire

// ==== design/hwce_conv_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module hwce_conv_engine (
  input  logic                                clk_fast_i,
  input  logic                                rst_n,
  input  logic                                clear_i,
  input  hwce_arith_pkg::sample_t             taps_i [hwce_arith_pkg::FILTER_SIZE],
  input  hwce_arith_pkg::sample_t             bias_i,
  input  logic [hwce_arith_pkg::QF_WIDTH-1:0] qf_i,
  input  logic                                relu_en_i,
  input  logic                                x_valid_i,
  input  hwce_arith_pkg::sample_t             x_data_i,
  output logic                                y_valid_o,
  output hwce_arith_pkg::sample_t             y_data_o
);

  // past samples, the incoming one completes the window
  hwce_arith_pkg::sample_t                  win_q   [hwce_arith_pkg::FILTER_SIZE-1];
  hwce_arith_pkg::sample_t                  win_nxt [hwce_arith_pkg::FILTER_SIZE];
  logic [hwce_arith_pkg::TAP_IDX_WIDTH-1:0] fill_q;

  hwce_arith_pkg::acc_t                     prod_q  [hwce_arith_pkg::FILTER_SIZE];
  logic                                     s1_vld_q;

  hwce_arith_pkg::acc_t                     sum;
  hwce_arith_pkg::acc_t                     shifted;
  hwce_arith_pkg::sample_t                  sat;
  hwce_arith_pkg::sample_t                  res;

  // tap 0 sees the newest sample
  always_comb begin
    win_nxt[0] = x_data_i;
    for (int k = 1; k < hwce_arith_pkg::FILTER_SIZE; k++) begin
      win_nxt[k] = win_q[k-1];
    end
  end

  ////////////////////
  // control
  ////////////////////
  always_ff @(posedge clk_fast_i) begin
    if (!rst_n) begin
      fill_q    <= '0;
      s1_vld_q  <= 1'b0;
      y_valid_o <= 1'b0;
    end else if (clear_i) begin
      // new taps, window refills and in-flight results drop
      fill_q    <= '0;
      s1_vld_q  <= 1'b0;
      y_valid_o <= 1'b0;
    end else begin
      s1_vld_q  <= x_valid_i && (fill_q == hwce_arith_pkg::LAST_TAP);
      y_valid_o <= s1_vld_q;
      if (x_valid_i && fill_q != hwce_arith_pkg::LAST_TAP) begin
        fill_q <= fill_q + 1'b1;
      end
    end
  end

  // stage 1, window shift and products
  always_ff @(posedge clk_fast_i) begin
    if (x_valid_i) begin
      for (int k = 0; k < hwce_arith_pkg::FILTER_SIZE - 1; k++) begin
        win_q[k] <= win_nxt[k];
      end
      for (int k = 0; k < hwce_arith_pkg::FILTER_SIZE; k++) begin
        prod_q[k] <= hwce_arith_pkg::acc_t'(taps_i[k]) * hwce_arith_pkg::acc_t'(win_nxt[k]);
      end
    end
  end

  ////////////////////
  // stage 2 arithmetic
  ////////////////////
  always_comb begin
    // bias is aligned to the product scale first
    sum = hwce_arith_pkg::acc_t'(bias_i) <<< qf_i;
    for (int k = 0; k < hwce_arith_pkg::FILTER_SIZE; k++) begin
      sum = sum + prod_q[k];
    end
    shifted = sum >>> qf_i;

    // in range when all upper bits match the sign
    if (&shifted[hwce_arith_pkg::ACC_WIDTH-1:hwce_arith_pkg::SAMPLE_WIDTH-1] ||
        ~|shifted[hwce_arith_pkg::ACC_WIDTH-1:hwce_arith_pkg::SAMPLE_WIDTH-1]) begin
      sat = shifted[hwce_arith_pkg::SAMPLE_WIDTH-1:0];
    end else if (shifted[hwce_arith_pkg::ACC_WIDTH-1]) begin
      sat = {1'b1, {(hwce_arith_pkg::SAMPLE_WIDTH-1){1'b0}}};
    end else begin
      sat = {1'b0, {(hwce_arith_pkg::SAMPLE_WIDTH-1){1'b1}}};
    end

    // rectifier
    if (relu_en_i && sat[hwce_arith_pkg::SAMPLE_WIDTH-1]) begin
      res = '0;
    end else begin
      res = sat;
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (s1_vld_q) begin
      y_data_o <= res;
    end
  end

  // a full window of fresh samples is needed after a reload
  a_no_early_output : assert property (
    @(posedge clk_fast_i) disable iff (!rst_n)
    clear_i |=> !y_valid_o [*hwce_arith_pkg::FILTER_SIZE+1]
  );

endmodule

`default_nettype wire

// ==== design/hwce_weight_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module hwce_weight_loader (
  input  logic                                       clk_fast_i,
  input  logic                                       rst_n,
  input  logic                                       start_i,
  input  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] base_addr_i,
  output logic                                       mem_rd_en_o,
  output logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] mem_rd_addr_o,
  input  hwce_arith_pkg::sample_t                    mem_rd_data_i,
  output hwce_arith_pkg::sample_t                    taps_o [hwce_arith_pkg::FILTER_SIZE],
  output logic                                       done_o
);

  hwce_cfg_pkg::loader_state_e                     state_q;
  logic [hwce_arith_pkg::TAP_IDX_WIDTH-1:0]        cnt_q;
  logic                                            rd_vld_q;
  logic [hwce_arith_pkg::TAP_IDX_WIDTH-1:0]        rd_idx_q;

  // one read per cycle while fetching
  assign mem_rd_en_o = (state_q == hwce_cfg_pkg::LD_FETCH);

  always_ff @(posedge clk_fast_i) begin
    if (!rst_n) begin
      state_q       <= hwce_cfg_pkg::LD_IDLE;
      cnt_q         <= '0;
      mem_rd_addr_o <= '0;
      rd_vld_q      <= 1'b0;
      rd_idx_q      <= '0;
      done_o        <= 1'b0;
    end else begin
      // remember which tap the data in flight belongs to
      rd_vld_q <= mem_rd_en_o;
      rd_idx_q <= cnt_q;
      done_o   <= 1'b0;
      case (state_q)
        hwce_cfg_pkg::LD_IDLE: begin
          if (start_i) begin
            state_q       <= hwce_cfg_pkg::LD_FETCH;
            cnt_q         <= '0;
            mem_rd_addr_o <= base_addr_i;
          end
        end
        hwce_cfg_pkg::LD_FETCH: begin
          // address wraps around the memory
          mem_rd_addr_o <= mem_rd_addr_o + 1'b1;
          cnt_q         <= cnt_q + 1'b1;
          if (cnt_q == hwce_arith_pkg::LAST_TAP) begin
            state_q <= hwce_cfg_pkg::LD_DRAIN;
          end
        end
        hwce_cfg_pkg::LD_DRAIN: begin
          // last word lands this cycle
          state_q <= hwce_cfg_pkg::LD_IDLE;
          done_o  <= 1'b1;
        end
        default: state_q <= hwce_cfg_pkg::LD_IDLE;
      endcase
    end
  end

  // tap capture, one cycle behind each read
  always_ff @(posedge clk_fast_i) begin
    if (rd_vld_q) begin
      taps_o[rd_idx_q] <= mem_rd_data_i;
    end
  end

  a_start_idle : assert property (
    @(posedge clk_fast_i) disable iff (!rst_n)
    start_i |-> state_q == hwce_cfg_pkg::LD_IDLE
  );

endmodule

`default_nettype wire

// ==== design/hwce_weight_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module hwce_weight_mem (
  input  logic                                       clk_fast_i,
  input  logic                                       wr_en_i,
  input  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] wr_addr_i,
  input  hwce_arith_pkg::sample_t                    wr_data_i,
  input  logic                                       rd_en_i,
  input  logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] rd_addr_i,
  output hwce_arith_pkg::sample_t                    rd_data_o
);

  hwce_arith_pkg::sample_t mem_q [hwce_arith_pkg::WMEM_DEPTH];

  // host side write port
  always_ff @(posedge clk_fast_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // loader side, registered read
  // data holds until the next enabled read
  always_ff @(posedge clk_fast_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== design/hwce_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module hwce_regfile (
  input  logic                                         clk_fast_i,
  input  logic                                         rst_n,
  input  logic                                         cfg_req_i,
  input  logic                                         cfg_we_i,
  input  hwce_cfg_pkg::cfg_reg_e                       cfg_addr_i,
  input  logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]      cfg_wdata_i,
  output logic                                         cfg_rvalid_o,
  output logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0]      cfg_rdata_o,
  input  logic                                         load_done_i,
  output logic                                         load_start_o,
  output logic [hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0]   wbase_o,
  output hwce_arith_pkg::sample_t                      bias_o,
  output logic [hwce_arith_pkg::QF_WIDTH-1:0]          qf_o,
  output logic                                         relu_en_o,
  output logic                                         evt_interrupt_o
);

  logic                                    busy_q;
  logic                                    wr_en;
  logic [hwce_cfg_pkg::CFG_DATA_WIDTH-1:0] rd_mux;

  assign wr_en = cfg_req_i & cfg_we_i;

  // read mux over the current register values
  always_comb begin
    rd_mux = '0;
    case (cfg_addr_i)
      hwce_cfg_pkg::REG_WBASE:  rd_mux[hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0] = wbase_o;
      hwce_cfg_pkg::REG_BIAS:   rd_mux = bias_o;
      hwce_cfg_pkg::REG_QF:     rd_mux[hwce_arith_pkg::QF_WIDTH-1:0] = qf_o;
      hwce_cfg_pkg::REG_FLAGS:  rd_mux[hwce_cfg_pkg::FLAG_RELU] = relu_en_o;
      hwce_cfg_pkg::REG_STATUS: rd_mux[hwce_cfg_pkg::STATUS_BUSY] = busy_q;
      default:                  rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_fast_i) begin
    if (!rst_n) begin
      cfg_rvalid_o    <= 1'b0;
      cfg_rdata_o     <= '0;
      wbase_o         <= '0;
      bias_o          <= '0;
      qf_o            <= '0;
      relu_en_o       <= 1'b0;
      busy_q          <= 1'b0;
      load_start_o    <= 1'b0;
      evt_interrupt_o <= 1'b0;
    end else begin
      // reads answer one cycle after the request
      cfg_rvalid_o <= cfg_req_i & ~cfg_we_i;
      cfg_rdata_o  <= rd_mux;

      if (wr_en) begin
        case (cfg_addr_i)
          hwce_cfg_pkg::REG_WBASE: wbase_o   <= cfg_wdata_i[hwce_arith_pkg::WMEM_ADDR_WIDTH-1:0];
          hwce_cfg_pkg::REG_BIAS:  bias_o    <= hwce_arith_pkg::sample_t'(cfg_wdata_i);
          hwce_cfg_pkg::REG_QF:    qf_o      <= cfg_wdata_i[hwce_arith_pkg::QF_WIDTH-1:0];
          hwce_cfg_pkg::REG_FLAGS: relu_en_o <= cfg_wdata_i[hwce_cfg_pkg::FLAG_RELU];
          default: ;
        endcase
      end

      ////////////////////
      // trigger and event
      ////////////////////
      load_start_o <= 1'b0;
      if (wr_en && cfg_addr_i == hwce_cfg_pkg::REG_TRIGGER && !busy_q) begin
        load_start_o <= 1'b1;
        busy_q       <= 1'b1;
      end
      // busy drops and the event fires together
      evt_interrupt_o <= load_done_i;
      if (load_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // loader only finishes a load that this block started
  a_done_while_busy : assert property (
    @(posedge clk_fast_i) disable iff (!rst_n)
    load_done_i |-> busy_q
  );

  // one event per load
  a_evt_single : assert property (
    @(posedge clk_fast_i) disable iff (!rst_n)
    evt_interrupt_o |=> !evt_interrupt_o
  );

endmodule

`default_nettype wire

// ==== design/hwce_cfg_pkg.sv ====
`default_nettype none

package hwce_cfg_pkg;

  // host configuration port
  localparam int CFG_ADDR_WIDTH = 3;
  localparam int CFG_DATA_WIDTH = 16;

  // register map, codes 6 and 7 are unused and read 0
  typedef enum logic [CFG_ADDR_WIDTH-1:0] {
    REG_TRIGGER = 3'd0,
    REG_WBASE   = 3'd1,
    REG_BIAS    = 3'd2,
    REG_QF      = 3'd3,
    REG_FLAGS   = 3'd4,
    REG_STATUS  = 3'd5
  } cfg_reg_e;

  // bit positions inside REG_FLAGS and REG_STATUS
  localparam int FLAG_RELU   = 0;
  localparam int STATUS_BUSY = 0;

  // weight loader FSM
  typedef enum logic [1:0] {
    LD_IDLE  = 2'd0,
    LD_FETCH = 2'd1,
    LD_DRAIN = 2'd2
  } loader_state_e;

endpackage

`default_nettype wire

// ==== design/hwce_arith_pkg.sv ====
`default_nettype none

package hwce_arith_pkg;

  // sample stream and filter taps
  localparam int SAMPLE_WIDTH = 16;
  localparam int FILTER_SIZE  = 5;

  // five full products plus the bias shifted by up to 15
  localparam int ACC_WIDTH = 40;

  // fixed-point shift field
  localparam int QF_WIDTH = 4;

  // weight memory geometry
  localparam int WMEM_DEPTH      = 64;
  localparam int WMEM_ADDR_WIDTH = 6;

  // tap index, shared by the loader and the engine fill counter
  localparam int TAP_IDX_WIDTH = $clog2(FILTER_SIZE);
  localparam logic [TAP_IDX_WIDTH-1:0] LAST_TAP = TAP_IDX_WIDTH'(FILTER_SIZE - 1);

  // samples, taps and bias
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // accumulator
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire
